/* list.f */
+incdir+verif
verilog/rv_isa_pkg.sv
verilog/trace_pkg.sv
verilog/insn_classifier.sv
verilog/mem_access_capture.sv
verilog/trace_fifo.sv
verilog/trace_ctrl.sv
verilog/pipeline_tracer.sv
verif/tb_pipeline_tracer.sv

/* verif/tb_trace_table.svh */
// add_step(behavior, fire {fetch, decode, execute, memory}, insn, class, sub, trace_ready)
// set_mem(addr, wdata, rdata) and set_wb(reg, data) extend the step added last
task automatic load_table();
  // Decode classification with one instruction per cycle
  add_step(1, 4'b0100, 32'h000000b7, CLS_LUI, SUB_NONE, 1'b1);
  add_step(1, 4'b0100, 32'h00000097, CLS_AUIPC, SUB_NONE, 1'b1);
  add_step(1, 4'b0100, 32'h0000006f, CLS_JAL, SUB_NONE, 1'b1);
  add_step(1, 4'b0100, 32'h00008067, CLS_JALR, SUB_NONE, 1'b1);
  add_step(1, 4'b0100, 32'h00002083, CLS_LOAD, SUB_NONE, 1'b1);
  add_step(1, 4'b0100, 32'h00112023, CLS_STORE, SUB_NONE, 1'b1);
  add_step(1, 4'b0100, 32'h00000063, CLS_BRANCH, SUB_BEQ, 1'b1);
  add_step(1, 4'b0100, 32'h00001063, CLS_BRANCH, SUB_BNE, 1'b1);
  add_step(1, 4'b0100, 32'h00004063, CLS_BRANCH, SUB_BLT, 1'b1);
  add_step(1, 4'b0100, 32'h00005063, CLS_BRANCH, SUB_BGE, 1'b1);
  add_step(1, 4'b0100, 32'h00006063, CLS_BRANCH, SUB_BLTU, 1'b1);
  add_step(1, 4'b0100, 32'h00007063, CLS_BRANCH, SUB_BGEU, 1'b1);
  add_step(1, 4'b0100, 32'h00002063, CLS_BRANCH, SUB_UNKNOWN, 1'b1);
  add_step(1, 4'b0100, 32'h00000033, CLS_ARITH, SUB_ADD, 1'b1);
  add_step(1, 4'b0100, 32'h40000033, CLS_ARITH, SUB_SUB, 1'b1);
  add_step(1, 4'b0100, 32'h00001033, CLS_ARITH, SUB_SLL, 1'b1);
  add_step(1, 4'b0100, 32'h00002033, CLS_ARITH, SUB_SLT, 1'b1);
  add_step(1, 4'b0100, 32'h00003033, CLS_ARITH, SUB_SLTU, 1'b1);
  add_step(1, 4'b0100, 32'h00004033, CLS_ARITH, SUB_XOR, 1'b1);
  add_step(1, 4'b0100, 32'h00005033, CLS_ARITH, SUB_SRL, 1'b1);
  add_step(1, 4'b0100, 32'h40005033, CLS_ARITH, SUB_SRA, 1'b1);
  add_step(1, 4'b0100, 32'h00006033, CLS_ARITH, SUB_OR, 1'b1);
  add_step(1, 4'b0100, 32'h00007033, CLS_ARITH, SUB_AND, 1'b1);
  // ADDI with bit 30 set stays ADD
  add_step(1, 4'b0100, 32'h40000013, CLS_ARITH_IMM, SUB_ADD, 1'b1);
  add_step(1, 4'b0100, 32'h40005013, CLS_ARITH_IMM, SUB_SRA, 1'b1);
  add_step(1, 4'b0100, 32'h0000007f, CLS_UNKNOWN, SUB_NONE, 1'b1);
  add_step(1, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  // Spaced fetch and execute events
  add_step(2, 4'b1000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  add_step(2, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  add_step(2, 4'b0010, 32'h40000033, CLS_ARITH, SUB_SUB, 1'b1);
  add_step(2, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  add_step(2, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  add_step(2, 4'b1010, 32'h00007063, CLS_BRANCH, SUB_BGEU, 1'b1);
  add_step(2, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  // Address and write data lead the memory event by one cycle
  add_step(3, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  set_mem(16'h1234, 16'hbeef, 32'h00000000);
  add_step(3, 4'b0001, 32'h00112023, CLS_STORE, SUB_NONE, 1'b1);
  set_mem(16'h5678, 16'h0a0a, 32'h00000000);
  add_step(3, 4'b0001, 32'h00002083, CLS_LOAD, SUB_NONE, 1'b1);
  set_mem(16'h9abc, 16'h0000, 32'hcafe0123);
  add_step(3, 4'b0001, 32'h00000033, CLS_ARITH, SUB_ADD, 1'b1);
  set_mem(16'hffff, 16'hffff, 32'hffffffff);
  add_step(3, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  // Register writes alone
  add_step(4, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  set_wb(5'd7, 32'h89abcdef);
  add_step(4, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  set_wb(5'd31, 32'h00000001);
  add_step(4, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
  // Six events against a stalled sink and then a drain
  repeat (6) add_step(5, 4'b1000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b0);
  repeat (6) add_step(5, 4'b0000, 32'h00000000, CLS_LUI, SUB_NONE, 1'b1);
endtask

/* verif/tb_pipeline_tracer.sv */
`timescale 1ns/100ps

module tb_pipeline_tracer;
  import rv_isa_pkg::*;
  import trace_pkg::*;

  typedef struct packed {
    logic [7:0]      test;
    logic [3:0]      fire;
    insn_t           insn;
    op_class_e       cls;
    sub_op_e         sub;
    logic            ready;
    mem_tap_t        mem;
    reg_write_t      wb;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result;
  } step_t;

  logic              clk;
  logic              rst;
  stage_tap_t        fetch_tap;
  stage_tap_t        decode_tap;
  stage_tap_t        execute_tap;
  stage_tap_t        memory_tap;
  mem_tap_t          mem_port;
  reg_write_t        reg_write;
  trace_rec_t        trace;
  logic              trace_valid;
  logic              trace_ready;
  logic [drop_w-1:0] drop_count;

  step_t             steps[$];
  trace_rec_t        expq[$];
  logic [drop_w-1:0] exp_drops;
  integer            seed = 32'hfd0;
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  int                limit = 1000;

  pipeline_tracer u_pipeline_tracer (
    .clk         (clk),
    .rst         (rst),
    .fetch_tap   (fetch_tap),
    .decode_tap  (decode_tap),
    .execute_tap (execute_tap),
    .memory_tap  (memory_tap),
    .mem_port    (mem_port),
    .reg_write   (reg_write),
    .trace       (trace),
    .trace_valid (trace_valid),
    .trace_ready (trace_ready),
    .drop_count  (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst) begin
      cycles++;
      if (cycles > limit) begin
        $display("Timeout after %0d cycles, the trace stream never drained", cycles);
        $display("Test FAILED");
        $finish;
      end
    end
  end

  task automatic add_step(input int test, input logic [3:0] fire, input insn_t insn,
                          input op_class_e cls, input sub_op_e sub, input logic ready);
    step_t s;
    s = '0;
    s.test = test[7:0];
    s.fire = fire;
    s.insn = insn;
    s.cls = cls;
    s.sub = sub;
    s.ready = ready;
    s.pc = $random(seed);
    s.result = $random(seed);
    steps.push_back(s);
  endtask

  task automatic set_mem(input logic [15:0] addr, input logic [15:0] wdata,
                         input logic [xlen-1:0] rdata);
    step_t s;
    s = steps.pop_back();
    s.mem.addr = addr;
    s.mem.wdata = wdata;
    s.mem.rdata = rdata;
    steps.push_back(s);
  endtask

  task automatic set_wb(input reg_idx_t rd, input logic [xlen-1:0] data);
    step_t s;
    s = steps.pop_back();
    s.wb.en = 1'b1;
    s.wb.addr = rd;
    s.wb.data = data;
    steps.push_back(s);
  endtask

  `include "tb_trace_table.svh"

  // An idle tap raises valid or ready but not both
  function automatic stage_tap_t make_tap(input logic fire, input step_t s);
    stage_tap_t t;
    t.valid = fire || s.pc[0];
    t.ready = fire || !s.pc[0];
    t.pc = s.pc;
    t.insn = s.insn;
    t.result = s.result;
    return t;
  endfunction

  task automatic apply_step(input step_t s);
    fetch_tap <= make_tap(s.fire[3], s);
    decode_tap <= make_tap(s.fire[2], s);
    execute_tap <= make_tap(s.fire[1], s);
    memory_tap <= make_tap(s.fire[0], s);
    mem_port <= s.mem;
    reg_write <= s.wb;
    trace_ready <= s.ready;
  endtask

  // Cycle numbers start at 1 after reset
  function automatic trace_rec_t expect_rec(input step_t s, input int idx,
                                            input logic [15:0] paddr, input logic [15:0] pwdata);
    trace_rec_t r;
    r = '0;
    r.cycle = cycle_w'(idx + 1);
    if (s.fire[3]) begin
      r.fetch_valid = 1'b1;
      r.fetch_pc = s.pc;
    end
    if (s.fire[2]) begin
      r.dec_valid = 1'b1;
      r.dec_class = s.cls;
      r.dec_sub = s.sub;
    end
    if (s.fire[1]) begin
      r.exe_valid = 1'b1;
      r.exe_class = s.cls;
      r.exe_sub = s.sub;
      r.exe_result = s.result;
    end
    if (s.fire[0]) begin
      r.mem_valid = 1'b1;
      r.mem_class = s.cls;
      if (s.cls == CLS_LOAD || s.cls == CLS_STORE) begin
        r.mem_is_access = 1'b1;
        r.mem_addr = paddr;
        r.mem_data = (s.cls == CLS_LOAD) ? s.mem.rdata : {16'h0000, pwdata};
      end
    end
    if (s.wb.en) begin
      r.wb_valid = 1'b1;
      r.wb_reg = s.wb.addr;
      r.wb_data = s.wb.data;
    end
    return r;
  endfunction

  task automatic check_class(input string name, input op_class_e got, input op_class_e exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch time=%0t signal=%s expected=%s (%0d) got=%s (%0d)",
               $time, name, exp.name(), exp, got.name(), got);
      errors++;
    end
  endtask

  task automatic check_sub(input string name, input sub_op_e got, input sub_op_e exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch time=%0t signal=%s expected=%s (%0d) got=%s (%0d)",
               $time, name, exp.name(), exp, got.name(), got);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [drop_w-1:0] got,
                             input logic [drop_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch time=%0t signal=%s expected=%0d got=%0d", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_rec(input trace_rec_t got, input trace_rec_t exp);
    trace_rec_t e;
    check_class("trace.dec_class", got.dec_class, exp.dec_class);
    check_sub("trace.dec_sub", got.dec_sub, exp.dec_sub);
    check_class("trace.exe_class", got.exe_class, exp.exe_class);
    check_sub("trace.exe_sub", got.exe_sub, exp.exe_sub);
    check_class("trace.mem_class", got.mem_class, exp.mem_class);
    // Enum fields were reported above
    e = exp;
    e.dec_class = got.dec_class;
    e.dec_sub = got.dec_sub;
    e.exe_class = got.exe_class;
    e.exe_sub = got.exe_sub;
    e.mem_class = got.mem_class;
    checks++;
    if (got !== e) begin
      $display("Mismatch time=%0t signal=trace expected=%h got=%h", $time, e, got);
      errors++;
    end
  endtask

  // Head must match while valid, whether or not the sink takes it
  task automatic observe_output(input logic ready);
    if (trace_valid) begin
      if (expq.size() == 0) begin
        $display("Extra record at %0t: cycle %0d came out with none expected",
                 $time, trace.cycle);
        errors++;
      end else begin
        check_rec(trace, expq[0]);
        if (ready) begin
          void'(expq.pop_front());
        end
      end
    end else if (expq.size() != 0) begin
      $display("Missing record at %0t: cycle %0d expected but trace_valid is low",
               $time, expq[0].cycle);
      errors++;
    end
  endtask

  task automatic predict_edge(input step_t s, input int idx,
                              input logic [15:0] paddr, input logic [15:0] pwdata);
    check_count("drop_count", drop_count, exp_drops);
    if (s.fire != 4'b0000 || s.wb.en) begin
      if (expq.size() < fifo_depth) begin
        expq.push_back(expect_rec(s, idx, paddr, pwdata));
      end else if (exp_drops != '1) begin
        exp_drops++;
      end
    end
  endtask

  initial begin
    step_t       idle;
    logic [15:0] prev_addr;
    logic [15:0] prev_wdata;
    int          test_err;
    bit          done;
    rst = 1'b1;
    fetch_tap = '0;
    decode_tap = '0;
    execute_tap = '0;
    memory_tap = '0;
    mem_port = '0;
    reg_write = '0;
    trace_ready = 1'b0;
    exp_drops = '0;
    prev_addr = '0;
    prev_wdata = '0;
    test_err = 0;
    load_table();
    limit = steps.size() + 20;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < steps.size(); i++) begin
      apply_step(steps[i]);
      @(negedge clk);
      observe_output(steps[i].ready);
      predict_edge(steps[i], i, prev_addr, prev_wdata);
      prev_addr = steps[i].mem.addr;
      prev_wdata = steps[i].mem.wdata;
      if (i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
        $display("Behavior %0d done: %0d errors", steps[i].test, errors - test_err);
        test_err = errors;
      end
      @(posedge clk);
    end
    idle = '0;
    idle.ready = 1'b1;
    done = 1'b0;
    while (!done) begin
      apply_step(idle);
      @(negedge clk);
      done = (expq.size() == 0) && !trace_valid;
      if (!done) begin
        observe_output(1'b1);
      end
      @(posedge clk);
    end
    @(negedge clk);
    check_count("drop_count", drop_count, exp_drops);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* verilog/insn_classifier.sv */
`timescale 1ns/100ps

module insn_classifier (
  input  rv_isa_pkg::insn_t     insn,
  output rv_isa_pkg::op_class_e op_class,
  output rv_isa_pkg::sub_op_e   sub_op
);
  import rv_isa_pkg::*;

  opcode_e opcode;
  funct3_t funct3;
  logic    alt;

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt = insn[30];

  always_comb begin
    op_class = CLS_UNKNOWN;
    sub_op = SUB_NONE;
    case (opcode)
      OP_LUI:   op_class = CLS_LUI;
      OP_AUIPC: op_class = CLS_AUIPC;
      OP_JAL:   op_class = CLS_JAL;
      OP_JALR:  op_class = CLS_JALR;
      OP_LOAD:  op_class = CLS_LOAD;
      OP_STORE: op_class = CLS_STORE;
      OP_BRANCH: begin
        op_class = CLS_BRANCH;
        case (funct3)
          f3_beq:  sub_op = SUB_BEQ;
          f3_bne:  sub_op = SUB_BNE;
          f3_blt:  sub_op = SUB_BLT;
          f3_bge:  sub_op = SUB_BGE;
          f3_bltu: sub_op = SUB_BLTU;
          f3_bgeu: sub_op = SUB_BGEU;
          default: sub_op = SUB_UNKNOWN;
        endcase
      end
      OP_ARITH_IMM, OP_ARITH: begin
        op_class = (opcode == OP_ARITH) ? CLS_ARITH : CLS_ARITH_IMM;
        case (funct3)
          // Bit 30 belongs to the immediate in ADDI
          f3_add_sub: sub_op = (alt && opcode == OP_ARITH) ? SUB_SUB : SUB_ADD;
          f3_sll:     sub_op = SUB_SLL;
          f3_slt:     sub_op = SUB_SLT;
          f3_sltu:    sub_op = SUB_SLTU;
          f3_xor:     sub_op = SUB_XOR;
          f3_srl_sra: sub_op = alt ? SUB_SRA : SUB_SRL;
          f3_or:      sub_op = SUB_OR;
          f3_and:     sub_op = SUB_AND;
          default:    sub_op = SUB_UNKNOWN;
        endcase
      end
      default: begin
        op_class = CLS_UNKNOWN;
        sub_op = SUB_NONE;
      end
    endcase
  end

  // Known instruction in, known class out
  always_comb begin
    if (!$isunknown(insn)) begin
      a_known_out: assert final (!$isunknown({op_class, sub_op}));
    end
  end

endmodule

/* verilog/mem_access_capture.sv */
`timescale 1ns/100ps

module mem_access_capture (
  input  logic                                clk,
  input  logic                                rst,
  input  trace_pkg::mem_tap_t                 mem_port,
  input  rv_isa_pkg::op_class_e               mem_class,
  output logic                                is_access,
  output logic [trace_pkg::mem_addr_w-1:0]    addr,
  output logic [rv_isa_pkg::xlen-1:0]         data
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  logic [mem_addr_w-1:0]  addr_q;
  logic [mem_wdata_w-1:0] wdata_q;

  // Address and write data lead the memory stage by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      addr_q <= '0;
      wdata_q <= '0;
    end else begin
      addr_q <= mem_port.addr;
      wdata_q <= mem_port.wdata;
    end
  end

  assign is_access = (mem_class == CLS_LOAD) || (mem_class == CLS_STORE);

  always_comb begin
    addr = '0;
    data = '0;
    case (mem_class)
      CLS_LOAD: begin
        addr = addr_q;
        data = mem_port.rdata;
      end
      CLS_STORE: begin
        addr = addr_q;
        data = {{(xlen - mem_wdata_w){1'b0}}, wdata_q};
      end
      default: ;
    endcase
  end

endmodule

/* verilog/pipeline_tracer.sv */
`timescale 1ns/100ps

module pipeline_tracer (
  input  logic                         clk,
  input  logic                         rst,
  input  trace_pkg::stage_tap_t        fetch_tap,
  input  trace_pkg::stage_tap_t        decode_tap,
  input  trace_pkg::stage_tap_t        execute_tap,
  input  trace_pkg::stage_tap_t        memory_tap,
  input  trace_pkg::mem_tap_t          mem_port,
  input  trace_pkg::reg_write_t        reg_write,
  output trace_pkg::trace_rec_t        trace,
  output logic                         trace_valid,
  input  logic                         trace_ready,
  output logic [trace_pkg::drop_w-1:0] drop_count
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  op_class_e             dec_class;
  op_class_e             exe_class;
  op_class_e             mem_class;
  sub_op_e               dec_sub;
  sub_op_e               exe_sub;
  logic                  mem_is_access;
  logic [mem_addr_w-1:0] mem_addr;
  logic [xlen-1:0]       mem_data;
  logic                  fifo_full;
  logic                  fifo_pop;
  logic                  push;
  trace_rec_t            rec;

  assign fifo_pop = trace_valid && trace_ready;

  insn_classifier u_dec_cls (
    .insn     (decode_tap.insn),
    .op_class (dec_class),
    .sub_op   (dec_sub)
  );

  insn_classifier u_exe_cls (
    .insn     (execute_tap.insn),
    .op_class (exe_class),
    .sub_op   (exe_sub)
  );

  // Memory record has no sub-operation field
  insn_classifier u_mem_cls (
    .insn     (memory_tap.insn),
    .op_class (mem_class),
    .sub_op   ()
  );

  mem_access_capture u_mem_access_capture (
    .clk       (clk),
    .rst       (rst),
    .mem_port  (mem_port),
    .mem_class (mem_class),
    .is_access (mem_is_access),
    .addr      (mem_addr),
    .data      (mem_data)
  );

  trace_ctrl u_trace_ctrl (
    .clk           (clk),
    .rst           (rst),
    .fetch_tap     (fetch_tap),
    .decode_tap    (decode_tap),
    .execute_tap   (execute_tap),
    .memory_tap    (memory_tap),
    .dec_class     (dec_class),
    .dec_sub       (dec_sub),
    .exe_class     (exe_class),
    .exe_sub       (exe_sub),
    .mem_class     (mem_class),
    .mem_is_access (mem_is_access),
    .mem_addr      (mem_addr),
    .mem_data      (mem_data),
    .reg_write     (reg_write),
    .fifo_full     (fifo_full),
    .fifo_pop      (fifo_pop),
    .push          (push),
    .rec           (rec),
    .drop_count    (drop_count)
  );

  trace_fifo u_trace_fifo (
    .clk        (clk),
    .rst        (rst),
    .push       (push),
    .din        (rec),
    .full       (fifo_full),
    .dout       (trace),
    .dout_valid (trace_valid),
    .pop_ready  (trace_ready)
  );

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int opcode_w = 7;
  localparam int funct3_w = 3;
  localparam int class_w = 4;
  localparam int sub_w = 5;
  localparam int reg_idx_w = 5;

  typedef logic [xlen-1:0] insn_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [funct3_w-1:0] funct3_t;

  // RV32I major opcodes in instruction bits 6:0
  typedef enum logic [opcode_w-1:0] {
    OP_LUI       = 7'b0110111,
    OP_AUIPC     = 7'b0010111,
    OP_JAL       = 7'b1101111,
    OP_JALR      = 7'b1100111,
    OP_BRANCH    = 7'b1100011,
    OP_LOAD      = 7'b0000011,
    OP_STORE     = 7'b0100011,
    OP_ARITH_IMM = 7'b0010011,
    OP_ARITH     = 7'b0110011
  } opcode_e;

  // Branch funct3
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

  // Arithmetic funct3 for both register and immediate forms
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  typedef enum logic [class_w-1:0] {
    CLS_LUI,
    CLS_AUIPC,
    CLS_JAL,
    CLS_JALR,
    CLS_BRANCH,
    CLS_LOAD,
    CLS_STORE,
    CLS_ARITH_IMM,
    CLS_ARITH,
    CLS_UNKNOWN
  } op_class_e;

  typedef enum logic [sub_w-1:0] {
    SUB_NONE,
    SUB_ADD,
    SUB_SUB,
    SUB_XOR,
    SUB_OR,
    SUB_AND,
    SUB_SLL,
    SUB_SRL,
    SUB_SRA,
    SUB_SLT,
    SUB_SLTU,
    SUB_BEQ,
    SUB_BNE,
    SUB_BLT,
    SUB_BGE,
    SUB_BLTU,
    SUB_BGEU,
    SUB_UNKNOWN
  } sub_op_e;

endpackage

/* verilog/trace_ctrl.sv */
`timescale 1ns/100ps

module trace_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  trace_pkg::stage_tap_t            fetch_tap,
  input  trace_pkg::stage_tap_t            decode_tap,
  input  trace_pkg::stage_tap_t            execute_tap,
  input  trace_pkg::stage_tap_t            memory_tap,
  input  rv_isa_pkg::op_class_e            dec_class,
  input  rv_isa_pkg::sub_op_e              dec_sub,
  input  rv_isa_pkg::op_class_e            exe_class,
  input  rv_isa_pkg::sub_op_e              exe_sub,
  input  rv_isa_pkg::op_class_e            mem_class,
  input  logic                             mem_is_access,
  input  logic [trace_pkg::mem_addr_w-1:0] mem_addr,
  input  logic [rv_isa_pkg::xlen-1:0]      mem_data,
  input  trace_pkg::reg_write_t            reg_write,
  input  logic                             fifo_full,
  input  logic                             fifo_pop,
  output logic                             push,
  output trace_pkg::trace_rec_t            rec,
  output logic [trace_pkg::drop_w-1:0]     drop_count
);
  import trace_pkg::*;

  logic [cycle_w-1:0] cycle_q;
  logic               fetch_fire;
  logic               dec_fire;
  logic               exe_fire;
  logic               mem_fire;
  logic               any_event;
  logic               drop;

  assign fetch_fire = fetch_tap.valid && fetch_tap.ready;
  assign dec_fire = decode_tap.valid && decode_tap.ready;
  assign exe_fire = execute_tap.valid && execute_tap.ready;
  assign mem_fire = memory_tap.valid && memory_tap.ready;
  assign any_event = fetch_fire || dec_fire || exe_fire || mem_fire || reg_write.en;

  assign push = any_event && (!fifo_full || fifo_pop);
  assign drop = any_event && fifo_full && !fifo_pop;

  always_comb begin
    rec = '0;
    // Record carries the count after this edge
    rec.cycle = cycle_q + 1'b1;
    if (fetch_fire) begin
      rec.fetch_valid = 1'b1;
      rec.fetch_pc = fetch_tap.pc;
    end
    if (dec_fire) begin
      rec.dec_valid = 1'b1;
      rec.dec_class = dec_class;
      rec.dec_sub = dec_sub;
    end
    if (exe_fire) begin
      rec.exe_valid = 1'b1;
      rec.exe_class = exe_class;
      rec.exe_sub = exe_sub;
      rec.exe_result = execute_tap.result;
    end
    if (mem_fire) begin
      rec.mem_valid = 1'b1;
      rec.mem_class = mem_class;
      rec.mem_is_access = mem_is_access;
      rec.mem_addr = mem_addr;
      rec.mem_data = mem_data;
    end
    if (reg_write.en) begin
      rec.wb_valid = 1'b1;
      rec.wb_reg = reg_write.addr;
      rec.wb_data = reg_write.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_q <= '0;
      drop_count <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      // Saturates at all ones
      if (drop && drop_count != '1) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

/* verilog/trace_fifo.sv */
`timescale 1ns/100ps

module trace_fifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push,
  input  trace_pkg::trace_rec_t din,
  output logic                  full,
  output trace_pkg::trace_rec_t dout,
  output logic                  dout_valid,
  input  logic                  pop_ready
);
  import trace_pkg::*;

  trace_rec_t            mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  pop;
  logic                  wr_en;

  assign pop = dout_valid && pop_ready;
  // Full still accepts when the head leaves at the same edge
  assign wr_en = push && (!full || pop);
  assign full = (count == (fifo_ptr_w + 1)'(fifo_depth));
  assign dout_valid = (count != '0);
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) push && full |-> pop);

  a_head_stable: assert property (@(posedge clk) disable iff (rst)
    dout_valid && !pop_ready |=> dout_valid && $stable(dout));

endmodule

/* verilog/trace_pkg.sv */
package trace_pkg;

  localparam int cycle_w = 16;
  localparam int fifo_depth = 4;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int drop_w = 8;

  // Data memory port is narrower than xlen
  localparam int mem_addr_w = 16;
  localparam int mem_wdata_w = 16;

  typedef struct packed {
    logic                          valid;
    logic                          ready;
    logic [rv_isa_pkg::xlen-1:0]   pc;
    rv_isa_pkg::insn_t             insn;
    logic [rv_isa_pkg::xlen-1:0]   result;
  } stage_tap_t;

  typedef struct packed {
    logic [mem_addr_w-1:0]         addr;
    logic [mem_wdata_w-1:0]        wdata;
    logic [rv_isa_pkg::xlen-1:0]   rdata;
  } mem_tap_t;

  typedef struct packed {
    logic                          en;
    rv_isa_pkg::reg_idx_t          addr;
    logic [rv_isa_pkg::xlen-1:0]   data;
  } reg_write_t;

  typedef struct packed {
    logic [cycle_w-1:0]            cycle;
    logic                          fetch_valid;
    logic [rv_isa_pkg::xlen-1:0]   fetch_pc;
    logic                          dec_valid;
    rv_isa_pkg::op_class_e         dec_class;
    rv_isa_pkg::sub_op_e           dec_sub;
    logic                          exe_valid;
    rv_isa_pkg::op_class_e         exe_class;
    rv_isa_pkg::sub_op_e           exe_sub;
    logic [rv_isa_pkg::xlen-1:0]   exe_result;
    logic                          mem_valid;
    rv_isa_pkg::op_class_e         mem_class;
    logic                          mem_is_access;
    logic [mem_addr_w-1:0]         mem_addr;
    logic [rv_isa_pkg::xlen-1:0]   mem_data;
    logic                          wb_valid;
    rv_isa_pkg::reg_idx_t          wb_reg;
    logic [rv_isa_pkg::xlen-1:0]   wb_data;
  } trace_rec_t;

endpackage
